// File: Makefile
# Verilator build and run of the instruction side testbench

VERILATOR ?= verilator
TOP       ?= tb_asap_fetch
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= TB PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard testbench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Output goes to the terminal, the status comes from the pass search
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: all.f
+incdir+testbench
common/asap_pkg.sv
common/imem_rw_if.sv
i_mem/i_mem.sv
src/fetch_unit.sv
src/imem_loader.sv
src/asap_fetch_top.sv
testbench/tb_asap_fetch.sv

// File: common/asap_pkg.sv
// Shared sizes, reset values and width types for the ASAP instruction side
`default_nettype none

package asap_pkg;

    // ------------------------------------------------------------------
    // Instruction memory geometry
    // ------------------------------------------------------------------

    // Total bytes held by the instruction memory
    localparam int I_MEM_BYTES = 4096;

    // Top byte index of the memory array
    localparam int I_MEM_MSB = I_MEM_BYTES - 1;

    // Bits needed to select one 32-bit word of the memory
    localparam int WORD_ADDR_W = 10;

    // ------------------------------------------------------------------
    // Width types
    // ------------------------------------------------------------------

    // Word index into the instruction memory
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;

    // Byte program counter
    typedef logic [31:0] pc_t;

    // One 32-bit RV32 instruction word
    typedef logic [31:0] instr_t;

    // One byte of the loader stream
    typedef logic [7:0] load_byte_t;

    // ------------------------------------------------------------------
    // Reset values
    // ------------------------------------------------------------------

    // First fetch address after reset
    localparam pc_t RESET_PC = 32'h0000_0000;

endpackage : asap_pkg

`default_nettype wire

// File: common/imem_rw_if.sv
// Shared read/write word port of the instruction memory
`default_nettype none
`timescale 1ns/1ns

interface imem_rw_if;
    import asap_pkg::*;

    // Word address of the access, read or write
    word_addr_t address;

    // Word to store when wren is high
    instr_t     wdata;

    // Write strobe, one word per cycle
    logic       wren;

    // Registered read data, one cycle after address
    instr_t     q;

    // Side that issues the accesses
    modport owner (
        output address,
        output wdata,
        output wren,
        input  q
    );

    // Memory side of the port
    modport mem (
        input  address,
        input  wdata,
        input  wren,
        output q
    );

endinterface : imem_rw_if

`default_nettype wire

// File: i_mem/i_mem.sv
// Byte-organized instruction memory with a read port and a read/write port
`default_nettype none
`timescale 1ns/1ns

module i_mem (
    input  logic                clock,
    input  asap_pkg::word_addr_t read_addr,
    output asap_pkg::instr_t    read_q,
    imem_rw_if.mem              rw
);
    import asap_pkg::*;

    // ------------------------------------------------------------------
    // Storage
    // ------------------------------------------------------------------

    // Behavioral byte array, simulation model only
    logic [7:0] mem_q    [I_MEM_MSB:0];
    logic [7:0] mem_next [I_MEM_MSB:0];

    // Unregistered words picked out of the current array
    instr_t read_word;
    instr_t rw_word;

    // ------------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------------

    // Only the shared port can write
    // Word lands little-endian at four times the word address
    always_comb begin : write_next
        mem_next = mem_q;
        if (rw.wren) begin
            mem_next[{rw.address, 2'b00}] = rw.wdata[7:0];
            mem_next[{rw.address, 2'b01}] = rw.wdata[15:8];
            mem_next[{rw.address, 2'b10}] = rw.wdata[23:16];
            mem_next[{rw.address, 2'b11}] = rw.wdata[31:24];
        end
    end

    // Array update at the end of the write cycle
    always_ff @(posedge clock) begin
        mem_q <= mem_next;
    end

    // ------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------

    // Fetch port word select
    assign read_word[7:0]   = mem_q[{read_addr, 2'b00}];
    assign read_word[15:8]  = mem_q[{read_addr, 2'b01}];
    assign read_word[23:16] = mem_q[{read_addr, 2'b10}];
    assign read_word[31:24] = mem_q[{read_addr, 2'b11}];

    // Shared port word select
    // Same-cycle write is not visible yet, so a collision returns old data
    assign rw_word[7:0]   = mem_q[{rw.address, 2'b00}];
    assign rw_word[15:8]  = mem_q[{rw.address, 2'b01}];
    assign rw_word[23:16] = mem_q[{rw.address, 2'b10}];
    assign rw_word[31:24] = mem_q[{rw.address, 2'b11}];

    // Synchronous read, data one cycle after the address
    always_ff @(posedge clock) begin
        read_q <= read_word;
        rw.q   <= rw_word;
    end

endmodule : i_mem

`default_nettype wire

// File: src/asap_fetch_top.sv
// Instruction side top joining loader, instruction memory and fetch
`default_nettype none
`timescale 1ns/1ns

module asap_fetch_top (
    input  logic                 clock,
    input  logic                 rst_n,
    // Byte load stream
    input  logic                 load_start,
    input  asap_pkg::word_addr_t load_addr,
    input  logic                 load_valid,
    input  asap_pkg::load_byte_t load_byte,
    // Debug reads
    input  logic                 dbg_rd,
    input  asap_pkg::word_addr_t dbg_addr,
    output logic                 dbg_valid,
    output asap_pkg::instr_t     dbg_data,
    // Fetch control
    input  logic                 run,
    input  logic                 stall,
    input  logic                 redirect,
    input  asap_pkg::pc_t        redirect_pc,
    // Fetched instructions
    output logic                 instr_valid,
    output asap_pkg::instr_t     instr,
    output asap_pkg::pc_t        instr_pc
);
    import asap_pkg::*;

    // ------------------------------------------------------------------
    // Internal connections
    // ------------------------------------------------------------------

    // Fetch read port
    word_addr_t fetch_addr;
    instr_t     fetch_instr;

    // Load and debug port
    imem_rw_if  imem_rw ();

    // ------------------------------------------------------------------
    // Blocks
    // ------------------------------------------------------------------

    // Byte loader and debug reader on the shared port
    imem_loader u_imem_loader (
        .clock      (clock),
        .rst_n      (rst_n),
        .load_start (load_start),
        .load_addr  (load_addr),
        .load_valid (load_valid),
        .load_byte  (load_byte),
        .dbg_rd     (dbg_rd),
        .dbg_addr   (dbg_addr),
        .dbg_valid  (dbg_valid),
        .dbg_data   (dbg_data),
        .mem        (imem_rw)
    );

    // Dual-port instruction memory
    i_mem u_i_mem (
        .clock     (clock),
        .read_addr (fetch_addr),
        .read_q    (fetch_instr),
        .rw        (imem_rw)
    );

    // PC and instruction fetch
    fetch_unit u_fetch_unit (
        .clock       (clock),
        .rst_n       (rst_n),
        .run         (run),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .fetch_addr  (fetch_addr),
        .fetch_instr (fetch_instr),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc)
    );

endmodule : asap_fetch_top

`default_nettype wire

// File: src/fetch_unit.sv
// Fetch stage with PC register, stall and redirect, and PC-tagged instruction output
`default_nettype none
`timescale 1ns/1ns

module fetch_unit (
    input  logic                 clock,
    input  logic                 rst_n,
    // Pipeline control
    input  logic                 run,
    input  logic                 stall,
    input  logic                 redirect,
    input  asap_pkg::pc_t        redirect_pc,
    // Memory read port
    output asap_pkg::word_addr_t fetch_addr,
    input  asap_pkg::instr_t     fetch_instr,
    // Fetched instruction toward decode
    output logic                 instr_valid,
    output asap_pkg::instr_t     instr,
    output asap_pkg::pc_t        instr_pc
);
    import asap_pkg::*;

    // ------------------------------------------------------------------
    // Program counter
    // ------------------------------------------------------------------

    // Current fetch PC, always presented to the memory
    pc_t  fetch_pc;
    pc_t  fetch_pc_next;

    // Word-aligned redirect target
    pc_t  redirect_target;

    // High when this cycle's read counts as a real request
    logic issue;

    // Redirect kills the read in flight this cycle
    // Stall alone only holds the PC
    assign issue = run && !stall && !redirect;

    // Low two bits dropped, no compressed instructions
    assign redirect_target = {redirect_pc[31:2], 2'b00};

    // Redirect first, then sequential advance, else hold
    always_comb begin : pc_next
        if (redirect) begin
            fetch_pc_next = redirect_target;
        end else if (issue) begin
            fetch_pc_next = fetch_pc + 32'd4;
        end else begin
            fetch_pc_next = fetch_pc;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            fetch_pc <= RESET_PC;
        end else begin
            fetch_pc <= fetch_pc_next;
        end
    end

    // Word index of the PC
    // Upper PC bits are ignored, so fetch wraps at the memory size
    assign fetch_addr = fetch_pc[WORD_ADDR_W+1:2];

    // ------------------------------------------------------------------
    // Request in flight
    // ------------------------------------------------------------------

    // One-deep record matching the memory's one cycle of latency
    logic issued_q;
    pc_t  issued_pc_q;

    // Issue bit is control state
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            issued_q <= 1'b0;
        end else begin
            issued_q <= issue;
        end
    end

    // PC tag of the read in flight
    always_ff @(posedge clock) begin
        issued_pc_q <= fetch_pc;
    end

    // ------------------------------------------------------------------
    // Response
    // ------------------------------------------------------------------

    // Valid follows the previous issue bit
    // A stall starting now still lets the earlier response through
    assign instr_valid = issued_q;
    assign instr_pc    = issued_pc_q;

    // Memory output is already registered
    assign instr       = fetch_instr;

endmodule : fetch_unit

`default_nettype wire

// File: src/imem_loader.sv
// Instruction memory loader that packs bytes into words, with a debug read path
`default_nettype none
`timescale 1ns/1ns

module imem_loader (
    input  logic                   clock,
    input  logic                   rst_n,
    // Byte load stream
    input  logic                   load_start,
    input  asap_pkg::word_addr_t   load_addr,
    input  logic                   load_valid,
    input  asap_pkg::load_byte_t   load_byte,
    // Debug read request and answer
    input  logic                   dbg_rd,
    input  asap_pkg::word_addr_t   dbg_addr,
    output logic                   dbg_valid,
    output asap_pkg::instr_t       dbg_data,
    // Shared memory port
    imem_rw_if.owner               mem
);
    import asap_pkg::*;

    // ------------------------------------------------------------------
    // Byte packing
    // ------------------------------------------------------------------

    // Bytes received so far for the current word
    logic [1:0]  byte_cnt;
    logic [1:0]  byte_cnt_eff;

    // Lower three bytes of the word, oldest byte ends in bits 7:0
    logic [23:0] word_q;

    // Write word address and the one seen by this cycle
    word_addr_t  wr_addr;
    word_addr_t  wr_addr_eff;

    // Word complete in this cycle
    logic        wr;

    // Start acts first, so a byte in the same cycle is byte 0
    assign byte_cnt_eff = load_start ? 2'd0 : byte_cnt;
    assign wr_addr_eff  = load_start ? load_addr : wr_addr;
    assign wr           = load_valid && (byte_cnt_eff == 2'd3);

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            byte_cnt <= 2'd0;
            wr_addr  <= '0;
        end else begin
            // Counter wraps from three to zero on the last byte
            if (load_valid) begin
                byte_cnt <= byte_cnt_eff + 2'd1;
            end else if (load_start) begin
                byte_cnt <= 2'd0;
            end
            // Auto-increment after each stored word
            if (wr) begin
                wr_addr <= wr_addr_eff + word_addr_t'(1);
            end else if (load_start) begin
                wr_addr <= load_addr;
            end
        end
    end

    // Shift right so the first byte settles lowest
    always_ff @(posedge clock) begin
        if (load_valid) begin
            word_q <= {load_byte, word_q[23:8]};
        end
    end

    // ------------------------------------------------------------------
    // Debug read and port arbitration
    // ------------------------------------------------------------------

    // Request waiting for a free port cycle
    logic       dbg_pend;
    word_addr_t dbg_pend_addr;

    // Request seen this cycle, a fresh pulse replaces the waiting one
    logic       dbg_req;
    word_addr_t dbg_req_addr;

    // Port carries a debug read this cycle
    logic       dbg_read;

    assign dbg_req      = dbg_rd || dbg_pend;
    assign dbg_req_addr = dbg_rd ? dbg_addr : dbg_pend_addr;
    assign dbg_read     = dbg_req && !wr;

    // Write wins the port, the read goes out otherwise
    assign mem.wren    = wr;
    assign mem.wdata   = {load_byte, word_q};
    assign mem.address = wr ? wr_addr_eff : dbg_req_addr;

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            dbg_pend  <= 1'b0;
            dbg_valid <= 1'b0;
        end else begin
            // Keep waiting only while a write holds the port
            dbg_pend  <= dbg_req && wr;
            dbg_valid <= dbg_read;
        end
    end

    always_ff @(posedge clock) begin
        if (dbg_req) begin
            dbg_pend_addr <= dbg_req_addr;
        end
    end

    // Port data is registered in the memory and lines up with dbg_valid
    assign dbg_data = mem.q;

endmodule : imem_loader

`default_nettype wire

// File: testbench/tb_fetch_model.svh
// Reference byte image with expected loader, debug and fetch behavior for the fetch testbench
`ifndef TB_FETCH_MODEL_SVH
`define TB_FETCH_MODEL_SVH

// ----------------------------------------------------------------------
// Byte image of the instruction memory
// ----------------------------------------------------------------------

// Updated at the end of each write cycle, like the real array
logic [7:0] model_bytes [0:I_MEM_MSB];

// Little-endian word at four times the word address
function automatic instr_t model_word(input word_addr_t wa);
    return {model_bytes[{wa, 2'b11}], model_bytes[{wa, 2'b10}],
            model_bytes[{wa, 2'b01}], model_bytes[{wa, 2'b00}]};
endfunction

function automatic void model_store(input word_addr_t wa, input instr_t w);
    model_bytes[{wa, 2'b00}] = w[7:0];
    model_bytes[{wa, 2'b01}] = w[15:8];
    model_bytes[{wa, 2'b10}] = w[23:16];
    model_bytes[{wa, 2'b11}] = w[31:24];
endfunction

// Background fill, every address bit shows up in the word
function automatic instr_t fill_word(input word_addr_t wa);
    return {6'h2a, wa, 6'h15, ~wa};
endfunction

// ----------------------------------------------------------------------
// Loader, debug and fetch state
// ----------------------------------------------------------------------

logic [1:0] ld_cnt;
word_addr_t ld_addr;
load_byte_t ld_buf [0:3];
logic       dbg_pend_m;
word_addr_t dbg_pend_addr_m;
pc_t        model_pc;

function automatic void model_reset();
    ld_cnt     = 2'd0;
    ld_addr    = '0;
    dbg_pend_m = 1'b0;
    model_pc   = RESET_PC;
endfunction

// One cycle of the byte stream; start first, fourth byte writes the word
function automatic void loader_step(input logic start, input word_addr_t addr,
                                    input logic valid, input load_byte_t b,
                                    output logic wr, output word_addr_t waddr,
                                    output instr_t wdata);
    if (start) begin
        ld_cnt  = 2'd0;
        ld_addr = addr;
    end
    wr    = valid && (ld_cnt == 2'd3);
    waddr = ld_addr;
    wdata = {b, ld_buf[2], ld_buf[1], ld_buf[0]};
    if (valid) begin
        ld_buf[ld_cnt] = b;
        ld_cnt         = ld_cnt + 2'd1;
    end
    if (wr) begin
        ld_addr = ld_addr + 10'd1;
    end
endfunction

// Debug read waits for a cycle without a write, newest request wins
function automatic void debug_step(input logic rd, input word_addr_t addr, input logic wr,
                                   output logic read, output word_addr_t raddr);
    logic req;
    req             = rd || dbg_pend_m;
    raddr           = rd ? addr : dbg_pend_addr_m;
    read            = req && !wr;
    dbg_pend_m      = req && wr;
    dbg_pend_addr_m = raddr;
endfunction

// Redirect over issue over hold
function automatic pc_t next_pc(input pc_t pc, input logic issue, input logic redir,
                                input pc_t target);
    if (redir) begin
        return target & ~32'h3;
    end
    if (issue) begin
        return pc + 32'd4;
    end
    return pc;
endfunction

`endif

// File: testbench/tb_asap_fetch.sv
// Testbench for the instruction side, checking loader, debug reads and fetch against a model
`default_nettype none
`timescale 1ns/1ns

module tb_asap_fetch;
    import asap_pkg::*;

    // Cycle budgets of the tests, summed for the watchdog
    localparam int RESET_CYCLES = 16;
    localparam int FILL_CYCLES  = I_MEM_BYTES + 8;
    localparam int LOAD_CYCLES  = 64 * 4 * 4 + 64 * 20;
    localparam int FETCH_CYCLES = 200 + 300 + 200 + 16 * 4 + 8 * 20 + 1100 + 16;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + FILL_CYCLES + LOAD_CYCLES
                                   + FETCH_CYCLES + 500;

    logic       clock;
    logic       rst_n;
    logic       load_start;
    word_addr_t load_addr;
    logic       load_valid;
    load_byte_t load_byte;
    logic       dbg_rd;
    word_addr_t dbg_addr;
    logic       dbg_valid;
    instr_t     dbg_data;
    logic       run;
    logic       stall;
    logic       redirect;
    pc_t        redirect_pc;
    logic       instr_valid;
    instr_t     instr;
    pc_t        instr_pc;

    // Run bookkeeping
    int          error_count = 0;
    int          issue_count = 0;
    int          valid_count = 0;
    int          dbg_count   = 0;
    string       test_name   = "reset";
    logic [31:0] lfsr        = 32'h17bd_98ce;

    `include "tb_fetch_model.svh"

    asap_fetch_top u_dut (
        .clock       (clock),
        .rst_n       (rst_n),
        .load_start  (load_start),
        .load_addr   (load_addr),
        .load_valid  (load_valid),
        .load_byte   (load_byte),
        .dbg_rd      (dbg_rd),
        .dbg_addr    (dbg_addr),
        .dbg_valid   (dbg_valid),
        .dbg_data    (dbg_data),
        .run         (run),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_pc    (instr_pc)
    );

    initial begin : clock_gen
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    // ------------------------------------------------------------------
    // Random numbers and reporting
    // ------------------------------------------------------------------

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            r[i] = lfsr[0];
        end
        return r;
    endfunction

    task automatic report_mismatch(input string what, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("FAILED %s: expected %h, actual %h", what, exp, act);
        error_count++;
    endtask

    // ------------------------------------------------------------------
    // Monitor, sampled mid-cycle where all outputs are settled
    // ------------------------------------------------------------------

    logic   in_reset = 1'b0;
    logic   exp_valid = 1'b0;
    pc_t    exp_pc;
    instr_t exp_instr;
    logic   exp_dbg_valid = 1'b0;
    instr_t exp_dbg_data;
    logic   jump_pending = 1'b0;
    pc_t    jump_target;
    logic   have_last = 1'b0;
    pc_t    last_pc;

    always @(negedge clock) begin : monitor
        logic       issue;
        logic       wr;
        word_addr_t waddr;
        instr_t     wdata;
        logic       dbg_read;
        word_addr_t dbg_raddr;
        if (!rst_n) begin
            if (in_reset && (instr_valid !== 1'b0 || dbg_valid !== 1'b0)) begin
                $display("ERROR: a valid output is high during reset");
                error_count++;
            end
            in_reset      = 1'b1;
            exp_valid     = 1'b0;
            exp_dbg_valid = 1'b0;
            model_reset();
        end else begin
            // Every response the DUT delivers counts toward the issue balance
            if (instr_valid === 1'b1) begin
                valid_count++;
            end
            // Responses for the previous cycle
            if (instr_valid !== exp_valid) begin
                report_mismatch({test_name, " instr_valid"}, 32'(exp_valid), 32'(instr_valid));
            end else if (exp_valid) begin
                if (instr_pc !== exp_pc) begin
                    report_mismatch({test_name, " instr_pc"}, exp_pc, instr_pc);
                end
                if (instr !== exp_instr) begin
                    report_mismatch({test_name, " instr"}, exp_instr, instr);
                end
                if (jump_pending && instr_pc !== jump_target) begin
                    report_mismatch({test_name, " redirect target"}, jump_target, instr_pc);
                end else if (!jump_pending && have_last && instr_pc !== last_pc + 32'd4) begin
                    report_mismatch({test_name, " pc sequence"}, last_pc + 32'd4, instr_pc);
                end
                have_last    = 1'b1;
                last_pc      = instr_pc;
                jump_pending = 1'b0;
            end
            if (dbg_valid !== exp_dbg_valid) begin
                report_mismatch({test_name, " dbg_valid"}, 32'(exp_dbg_valid), 32'(dbg_valid));
            end else if (exp_dbg_valid) begin
                dbg_count++;
                if (dbg_data !== exp_dbg_data) begin
                    report_mismatch({test_name, " dbg_data"}, exp_dbg_data, dbg_data);
                end
            end
            // Reads of this cycle see the image before this cycle's write
            issue     = run && !stall && !redirect;
            exp_valid = issue;
            exp_pc    = model_pc;
            exp_instr = model_word(model_pc[WORD_ADDR_W+1:2]);
            if (issue) begin
                issue_count++;
            end
            if (redirect) begin
                jump_pending = 1'b1;
                jump_target  = redirect_pc & ~32'h3;
            end
            model_pc = next_pc(model_pc, issue, redirect, redirect_pc);
            loader_step(load_start, load_addr, load_valid, load_byte, wr, waddr, wdata);
            debug_step(dbg_rd, dbg_addr, wr, dbg_read, dbg_raddr);
            exp_dbg_valid = dbg_read;
            exp_dbg_data  = model_word(dbg_raddr);
            if (wr) begin
                model_store(waddr, wdata);
            end
        end
    end

    // ------------------------------------------------------------------
    // Stimulus tasks, inputs change 1 ns after the rising edge
    // ------------------------------------------------------------------

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic idle_inputs();
        load_start  = 1'b0;
        load_addr   = '0;
        load_valid  = 1'b0;
        load_byte   = '0;
        dbg_rd      = 1'b0;
        dbg_addr    = '0;
        run         = 1'b0;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
    endtask

    task automatic wait_dbg_answer(input word_addr_t wa, input instr_t expected);
        int waited;
        waited = 0;
        @(negedge clock);
        while (dbg_valid !== 1'b1 && waited < 16) begin
            waited++;
            @(negedge clock);
        end
        if (dbg_valid !== 1'b1) begin
            $display("ERROR: %s debug read of word %h was never answered", test_name, wa);
            error_count++;
        end else if (dbg_data !== expected) begin
            report_mismatch({test_name, " read back"}, expected, dbg_data);
        end
        // Back to the drive point just after the next rising edge
        next_cycle();
    endtask

    task automatic debug_read(input word_addr_t wa, input instr_t expected);
        dbg_rd   = 1'b1;
        dbg_addr = wa;
        next_cycle();
        dbg_rd = 1'b0;
        wait_dbg_answer(wa, expected);
    endtask

    // Four bytes, optional idle gaps, optional debug read on the writing cycle
    task automatic load_word(input instr_t w, input logic gaps, input logic start,
                             input word_addr_t wa, input logic probe);
        for (int i = 0; i < 4; i++) begin
            if (gaps) begin
                repeat (rand_bits(2)) next_cycle();
            end
            load_start = start && (i == 0);
            load_addr  = wa;
            load_valid = 1'b1;
            load_byte  = w[8*i +: 8];
            dbg_rd     = probe && (i == 3);
            dbg_addr   = wa;
            next_cycle();
            load_start = 1'b0;
            load_valid = 1'b0;
            dbg_rd     = 1'b0;
        end
        if (probe) begin
            wait_dbg_answer(wa, w);
        end
    endtask

    // ------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------

    initial begin : stimulus
        word_addr_t base;
        instr_t     words [64];
        idle_inputs();
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clock);
        #1;
        rst_n = 1'b1;
        next_cycle();

        // Background image over the whole memory
        test_name = "fill";
        for (int a = 0; a < I_MEM_BYTES / 4; a++) begin
            load_word(fill_word(word_addr_t'(a)), 1'b0, a == 0, word_addr_t'(a), 1'b0);
        end

        test_name = "load_readback";
        base = word_addr_t'(rand_bits(WORD_ADDR_W));
        for (int i = 0; i < 64; i++) begin
            words[i] = rand_bits(32);
            load_word(words[i], 1'b1, i == 0, word_addr_t'(base + i), 1'b0);
        end
        for (int i = 0; i < 64; i++) begin
            debug_read(word_addr_t'(base + i), words[i]);
        end

        test_name = "seq_fetch";
        run = 1'b1;
        repeat (200) next_cycle();

        test_name = "random_stall";
        repeat (300) begin
            stall = (rand_bits(2) == 32'd0);
            next_cycle();
        end

        // Unaligned targets, mixed with stalls
        test_name = "redirect";
        repeat (200) begin
            stall       = (rand_bits(3) == 32'd0);
            redirect    = (rand_bits(3) == 32'd0);
            redirect_pc = rand_bits(32) | 32'h1;
            next_cycle();
        end
        stall    = 1'b0;
        redirect = 1'b0;

        // New words land while fetch laps the whole memory
        test_name = "load_during_fetch";
        base = word_addr_t'(rand_bits(WORD_ADDR_W));
        for (int i = 0; i < 16; i++) begin
            load_word(rand_bits(32), 1'b0, i == 0, word_addr_t'(base + i), i % 2 == 1);
        end
        repeat (1100) next_cycle();
        run = 1'b0;
        next_cycle();
        next_cycle();

        if (valid_count != issue_count) begin
            $display("ERROR: %0d fetch responses for %0d issue cycles", valid_count, issue_count);
            error_count++;
        end
        $display("Summary: %0d errors, %0d fetch responses, %0d issues, %0d debug answers",
                 error_count, valid_count, issue_count, dbg_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clock);
        $display("ERROR: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TB FAILED");
        $finish;
    end

endmodule : tb_asap_fetch

`default_nettype wire
